//--- hdl/xaui_mgmt_pkg.sv
package xaui_mgmt_pkg;

  // Four XAUI lanes, each carrying two bytes per mgt_clk cycle.
  localparam int NUM_LANES = 4;

  // A lane counts as synced after this many consecutive good cycles.
  localparam int SYNC_GOOD_CYCLES = 4;

  // Length of one stretched receive reset pulse, in cycles.
  localparam int STRETCH_CYCLES = 15;

  typedef enum logic {
    SEQ_LOOK    = 1'b0,
    SEQ_HOLDOFF = 1'b1
  } seq_state_e;

  // Bit positions in the eight-bit status vector.
  localparam int STAT_BUF_FAULT  = 0;
  localparam int STAT_CODE_FAULT = 1;
  // Lane sync flags occupy STAT_SYNC_LO up to STAT_SYNC_LO + NUM_LANES - 1.
  localparam int STAT_SYNC_LO    = 2;
  localparam int STAT_ALIGN      = 6;
  localparam int STAT_RX_RESET   = 7;

endpackage

//--- hdl/xaui_mgmt_ifs.sv
// Lane health as seen by the sync monitor.
interface lane_status_if import xaui_mgmt_pkg::*; ();

  logic [NUM_LANES-1:0] lane_sync;
  logic                 aligned;
  logic                 lanes_locked;
  logic                 sync_lost_event;

  modport mon (
    output lane_sync,
    output aligned,
    output lanes_locked,
    output sync_lost_event
  );

  modport seq (
    input lane_sync,
    input aligned,
    input lanes_locked,
    input sync_lost_event
  );

endinterface

// Receive fault state kept by the fault tracker.
interface rx_fault_if import xaui_mgmt_pkg::*; ();

  logic                 buf_fault;
  logic                 code_fault;
  logic                 buf_err_now;
  logic [NUM_LANES-1:0] err_lanes;

  modport trk (
    output buf_fault,
    output code_fault,
    output buf_err_now,
    output err_lanes
  );

  modport seq (
    input buf_fault,
    input code_fault,
    input buf_err_now,
    input err_lanes
  );

endinterface

//--- hdl/lane_sync_monitor.sv
module lane_sync_monitor import xaui_mgmt_pkg::*; (
  input  logic                   mgt_clk,
  input  logic                   mgt_rx_reset_stretch,
  input  logic [NUM_LANES-1:0]   mgt_rxlock,
  input  logic [NUM_LANES-1:0]   mgt_syncok,
  input  logic [2*NUM_LANES-1:0] mgt_code_valid,
  input  logic [2*NUM_LANES-1:0] mgt_code_comma,
  output logic [NUM_LANES-1:0]   mgt_enable_align,
  output logic                   mgt_en_chan_sync,
  lane_status_if.mon             status
);

  localparam int CNT_W = $clog2(SYNC_GOOD_CYCLES);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(SYNC_GOOD_CYCLES - 1);

  logic [NUM_LANES-1:0] lane_good;
  logic [NUM_LANES-1:0] low_comma;
  logic [NUM_LANES-1:0] sync_next;
  logic [CNT_W-1:0]     good_cnt [NUM_LANES];

  // A lane is good when locked, synced and both of its bytes decode.
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_good[i] = mgt_rxlock[i] & mgt_syncok[i] & (&mgt_code_valid[2*i +: 2]);
      low_comma[i] = mgt_code_comma[2*i];
      sync_next[i] = lane_good[i] & (status.lane_sync[i] | (good_cnt[i] == CNT_MAX));
    end
  end

  always_ff @(posedge mgt_clk) begin
    if (mgt_rx_reset_stretch) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        good_cnt[i] <= '0;
      end
      status.lane_sync       <= '0;
      status.aligned         <= 1'b0;
      status.lanes_locked    <= 1'b0;
      status.sync_lost_event <= 1'b0;
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (!lane_good[i]) begin
          good_cnt[i] <= '0;
        end else if (good_cnt[i] != CNT_MAX) begin
          good_cnt[i] <= good_cnt[i] + 1'b1;
        end
      end
      status.lane_sync <= sync_next;
      // Alignment is taken on a common comma and dropped together with any lane.
      status.aligned <= (&sync_next) &
                        (status.aligned | ((&status.lane_sync) & (&low_comma)));
      status.lanes_locked    <= &mgt_rxlock;
      status.sync_lost_event <= |(status.lane_sync & ~sync_next);
    end
  end

  assign mgt_enable_align = ~status.lane_sync;

  // Channel bonding runs once every lane has sync but deskew is not yet done.
  assign mgt_en_chan_sync = (&status.lane_sync) & ~status.aligned;

  a_aligned_needs_sync: assert property (
    @(posedge mgt_clk) disable iff (mgt_rx_reset_stretch)
    status.aligned |-> (&status.lane_sync)
  );

endmodule

//--- hdl/rx_fault_tracker.sv
module rx_fault_tracker import xaui_mgmt_pkg::*; (
  input  logic                   mgt_clk,
  input  logic                   mgt_rx_reset_stretch,
  input  logic                   xaui_reset,
  input  logic [NUM_LANES-1:0]   mgt_rxbufferr,
  input  logic [2*NUM_LANES-1:0] mgt_code_valid,
  input  logic [NUM_LANES-1:0]   mgt_rxlock,
  output logic [7:0]             error_count,
  rx_fault_if.trk                faults
);

  localparam logic [7:0] ERR_MAX = 8'hff;

  logic                 all_locked;
  logic [NUM_LANES-1:0] code_err;
  logic                 any_err;

  assign all_locked = &mgt_rxlock;

  // Code errors only count while every receiver is locked.
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      code_err[i] = all_locked & ~(&mgt_code_valid[2*i +: 2]);
    end
  end

  assign any_err            = (|mgt_rxbufferr) | (|code_err);
  assign faults.buf_err_now = |mgt_rxbufferr;

  always_ff @(posedge mgt_clk) begin
    if (mgt_rx_reset_stretch || xaui_reset) begin
      faults.buf_fault  <= 1'b0;
      faults.code_fault <= 1'b0;
      faults.err_lanes  <= '0;
      error_count       <= '0;
    end else begin
      if (|mgt_rxbufferr) begin
        faults.buf_fault <= 1'b1;
      end
      if (|code_err) begin
        faults.code_fault <= 1'b1;
      end
      faults.err_lanes <= faults.err_lanes | mgt_rxbufferr | code_err;
      if (any_err && error_count != ERR_MAX) begin
        error_count <= error_count + 8'd1;
      end
    end
  end

  a_count_monotonic: assert property (
    @(posedge mgt_clk) disable iff (mgt_rx_reset_stretch)
    (!$past(xaui_reset) && !$past(mgt_rx_reset_stretch)) |->
      (error_count >= $past(error_count))
  );

endmodule

//--- hdl/rx_reset_sequencer.sv
module rx_reset_sequencer import xaui_mgmt_pkg::*; #(
  parameter int HOLDOFF_BITS = 24
) (
  input  logic                 mgt_clk,
  input  logic                 mgt_rx_reset_stretch,
  input  logic                 xaui_reset,
  lane_status_if.seq           status,
  rx_fault_if.seq              faults,
  output logic [NUM_LANES-1:0] mgt_rx_reset,
  output logic [7:0]           xaui_status
);

  localparam int STRETCH_W = $clog2(STRETCH_CYCLES + 1);

  seq_state_e              state;
  logic [HOLDOFF_BITS-1:0] holdoff_cnt;
  logic [STRETCH_W-1:0]    stretch_cnt;
  logic                    healthy;
  logic                    pulse_on;
  logic                    fire;
  logic [7:0]              status_d;

  assign healthy = status.aligned & (&status.lane_sync) & status.lanes_locked &
                   ~status.sync_lost_event & ~faults.buf_err_now;

  assign pulse_on = (stretch_cnt != '0);

  // A new reset is only launched from SEQ_LOOK, and never on top of a running pulse.
  assign fire = (state == SEQ_LOOK) & ~healthy & ~pulse_on & ~xaui_reset;

  always_ff @(posedge mgt_clk) begin
    if (mgt_rx_reset_stretch || xaui_reset) begin
      state       <= SEQ_LOOK;
      holdoff_cnt <= '0;
    end else begin
      case (state)
        SEQ_LOOK: begin
          if (fire) begin
            holdoff_cnt <= '1;
            state       <= SEQ_HOLDOFF;
          end
        end
        SEQ_HOLDOFF: begin
          if (holdoff_cnt != '0) begin
            holdoff_cnt <= holdoff_cnt - 1'b1;
          end else begin
            state <= SEQ_LOOK;
          end
        end
        default: state <= SEQ_LOOK;
      endcase
    end
  end

  // The stretcher keeps running through xaui_reset.
  always_ff @(posedge mgt_clk) begin
    if (mgt_rx_reset_stretch) begin
      stretch_cnt <= '0;
    end else if (fire) begin
      stretch_cnt <= STRETCH_W'(STRETCH_CYCLES);
    end else if (pulse_on) begin
      stretch_cnt <= stretch_cnt - 1'b1;
    end
  end

  assign mgt_rx_reset = {NUM_LANES{pulse_on}};

  always_comb begin
    status_d                              = '0;
    status_d[STAT_BUF_FAULT]              = faults.buf_fault;
    status_d[STAT_CODE_FAULT]             = faults.code_fault;
    status_d[STAT_SYNC_LO +: NUM_LANES]   = status.lane_sync;
    status_d[STAT_ALIGN]                  = status.aligned;
    status_d[STAT_RX_RESET]               = pulse_on;
  end

  always_ff @(posedge mgt_clk) begin
    if (mgt_rx_reset_stretch) begin
      xaui_status <= '0;
    end else begin
      xaui_status <= status_d;
    end
  end

  a_reset_from_look: assert property (
    @(posedge mgt_clk) disable iff (mgt_rx_reset_stretch)
    $rose(pulse_on) |-> ($past(state) == SEQ_LOOK)
  );

  a_pulse_length: assert property (
    @(posedge mgt_clk) disable iff (mgt_rx_reset_stretch)
    $rose(pulse_on) |-> ##STRETCH_CYCLES !pulse_on
  );

  // A sticky buffer fault in the tracker always has a lane to blame.
  a_fault_has_lane: assert property (
    @(posedge mgt_clk) disable iff (mgt_rx_reset_stretch)
    faults.buf_fault |-> (|faults.err_lanes)
  );

endmodule

//--- hdl/xaui_phy_mgmt.sv
module xaui_phy_mgmt import xaui_mgmt_pkg::*; #(
  parameter int HOLDOFF_BITS = 24
) (
  input  logic                   mgt_clk,
  input  logic                   mgt_rx_reset_stretch,
  input  logic [NUM_LANES-1:0]   mgt_rxlock,
  input  logic [NUM_LANES-1:0]   mgt_syncok,
  input  logic [2*NUM_LANES-1:0] mgt_code_valid,
  input  logic [2*NUM_LANES-1:0] mgt_code_comma,
  input  logic [NUM_LANES-1:0]   mgt_rxbufferr,
  input  logic                   xaui_reset,
  output logic [NUM_LANES-1:0]   mgt_enable_align,
  output logic                   mgt_en_chan_sync,
  output logic [NUM_LANES-1:0]   mgt_rx_reset,
  output logic [7:0]             xaui_status,
  output logic [7:0]             error_count
);

  lane_status_if lane_status ();
  rx_fault_if    rx_faults ();

  lane_sync_monitor u_lane_sync_monitor (
    .mgt_clk              (mgt_clk),
    .mgt_rx_reset_stretch (mgt_rx_reset_stretch),
    .mgt_rxlock           (mgt_rxlock),
    .mgt_syncok           (mgt_syncok),
    .mgt_code_valid       (mgt_code_valid),
    .mgt_code_comma       (mgt_code_comma),
    .mgt_enable_align     (mgt_enable_align),
    .mgt_en_chan_sync     (mgt_en_chan_sync),
    .status               (lane_status.mon)
  );

  rx_fault_tracker u_rx_fault_tracker (
    .mgt_clk              (mgt_clk),
    .mgt_rx_reset_stretch (mgt_rx_reset_stretch),
    .xaui_reset           (xaui_reset),
    .mgt_rxbufferr        (mgt_rxbufferr),
    .mgt_code_valid       (mgt_code_valid),
    .mgt_rxlock           (mgt_rxlock),
    .error_count          (error_count),
    .faults               (rx_faults.trk)
  );

  rx_reset_sequencer #(
    .HOLDOFF_BITS (HOLDOFF_BITS)
  ) u_rx_reset_sequencer (
    .mgt_clk              (mgt_clk),
    .mgt_rx_reset_stretch (mgt_rx_reset_stretch),
    .xaui_reset           (xaui_reset),
    .status               (lane_status.seq),
    .faults               (rx_faults.seq),
    .mgt_rx_reset         (mgt_rx_reset),
    .xaui_status          (xaui_status)
  );

endmodule

//--- tb/tb_xaui_phy_mgmt.sv
module tb_xaui_phy_mgmt import xaui_mgmt_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HOLDOFF_BITS = 6;
  localparam int DROP_LANE = 1;
  localparam logic [31:0] LFSR_SEED = 32'hec2f;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam logic [7:0] BUF_BIT = 8'(1 << STAT_BUF_FAULT);
  localparam logic [7:0] CODE_BIT = 8'(1 << STAT_CODE_FAULT);
  localparam logic [7:0] SYNC_BITS = 8'(((1 << NUM_LANES) - 1) << STAT_SYNC_LO);
  localparam logic [7:0] ALIGN_BIT = 8'(1 << STAT_ALIGN);
  localparam logic [7:0] RX_BIT = 8'(1 << STAT_RX_RESET);
  localparam logic [7:0] DROP_BIT = 8'(1 << (STAT_SYNC_LO + DROP_LANE));
  // Rise to rise is 63 hold-off edges, one edge back to look and one edge to fire again.
  localparam int RETRY_GAP = (2 ** HOLDOFF_BITS - 1) + 2 - STRETCH_CYCLES;
  localparam int QUIET_CYCLES = 2 ** HOLDOFF_BITS + 32;

  logic        mgt_clk = 1'b0;
  logic        mgt_rx_reset_stretch;
  logic [3:0]  mgt_rxlock;
  logic [3:0]  mgt_syncok;
  logic [7:0]  mgt_code_valid;
  logic [7:0]  mgt_code_comma;
  logic [3:0]  mgt_rxbufferr;
  logic        xaui_reset;
  logic [3:0]  mgt_enable_align;
  logic        mgt_en_chan_sync;
  logic [3:0]  mgt_rx_reset;
  logic [7:0]  xaui_status;
  logic [7:0]  error_count;
  int          mismatches;
  int          timeouts;
  logic [31:0] lfsr_state;

  xaui_phy_mgmt #(.HOLDOFF_BITS(HOLDOFF_BITS)) UUT (.*);

  initial begin
    forever #10 mgt_clk = ~mgt_clk;
  end

  initial begin
    #200000;
    $display("Watchdog expired before the tests finished");
    $display("sim failed");
    $finish;
  end

  function automatic logic [7:0] lfsr_take(input int n);
    logic [7:0] v;
    v = '0;
    repeat (n) begin
      v = {v[6:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
    end
    return v;
  endfunction

  task automatic check_status(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("ERROR at %0d ns: %s: status %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_lanes(input logic [3:0] got, input logic [3:0] exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("ERROR at %0d ns: %s: lanes %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("ERROR at %0d ns: %s: count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_cycles(input int got, input int exp, input string what);
    if (got != exp) begin
      mismatches++;
      $display("ERROR at %0d ns: %s: %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic wait_status(input logic [7:0] mask, input logic [7:0] value, input int limit,
                             input string what);
    int n;
    n = 0;
    while ((xaui_status & mask) != value && n < limit) begin
      @(negedge mgt_clk);
      n++;
    end
    if ((xaui_status & mask) != value) begin
      timeouts++;
      $display("Timed out after %0d cycles waiting for the %s", limit, what);
    end
  endtask

  // Counts samples while the receive reset holds the given level.
  task automatic run_length(input logic level, input int limit, output int n);
    n = 0;
    while ((|mgt_rx_reset) == level && n < limit) begin
      @(negedge mgt_clk);
      n++;
    end
  endtask

  task automatic expect_quiet(input int cycles, input string what);
    logic [3:0] seen;
    seen = '0;
    repeat (cycles) begin
      @(negedge mgt_clk);
      seen = seen | mgt_rx_reset;
    end
    check_lanes(seen, 4'h0, what);
  endtask

  task automatic pulse_xaui_reset();
    @(negedge mgt_clk);
    xaui_reset = 1'b1;
    @(negedge mgt_clk);
    xaui_reset = 1'b0;
    @(negedge mgt_clk);
  endtask

  task automatic link_bringup();
    int n;
    mgt_rxlock = '1;
    mgt_syncok = '1;
    mgt_code_valid = '1;
    wait_status(SYNC_BITS, SYNC_BITS, 4 * SYNC_GOOD_CYCLES, "lane sync bits");
    check_lanes({3'b000, mgt_en_chan_sync}, 4'h1, "bonding enable before alignment");
    check_lanes(mgt_enable_align, 4'h0, "comma align enables once synced");
    check_status(xaui_status & ALIGN_BIT, 8'h00, "align bit without commas");
    // The low byte of each lane carries the comma.
    mgt_code_comma = 8'h55;
    wait_status(ALIGN_BIT, ALIGN_BIT, 4, "align bit");
    check_lanes({3'b000, mgt_en_chan_sync}, 4'h0, "bonding enable after alignment");
    run_length(1'b1, 2 * STRETCH_CYCLES, n);
    expect_quiet(QUIET_CYCLES, "receive reset on a healthy link");
    check_status(xaui_status, SYNC_BITS | ALIGN_BIT, "healthy status");
  endtask

  task automatic sync_loss_pulse();
    int n;
    mgt_syncok[DROP_LANE] = 1'b0;
    run_length(1'b0, 4, n);
    // One edge clears the lane and the next one sees the unhealthy link.
    check_cycles(n, 2, "delay from sync loss to receive reset");
    check_lanes(mgt_rx_reset, 4'hf, "receive reset after sync loss");
    // The reset bit of the status vector is still one cycle behind here.
    check_status(xaui_status, SYNC_BITS & ~DROP_BIT, "status after sync loss");
    run_length(1'b1, 2 * STRETCH_CYCLES, n);
    check_cycles(n, STRETCH_CYCLES, "first receive reset length");
    // The status copy of the reset lags by one cycle and is still set here.
    check_status(xaui_status, (SYNC_BITS & ~DROP_BIT) | RX_BIT, "status at the end of the pulse");
    run_length(1'b0, 2 * RETRY_GAP, n);
    check_cycles(n, RETRY_GAP, "gap before the retry");
  endtask

  task automatic holdoff_retry();
    int n;
    check_lanes(mgt_rx_reset, 4'hf, "retry after the hold-off");
    run_length(1'b1, 2 * STRETCH_CYCLES, n);
    check_cycles(n, STRETCH_CYCLES, "second receive reset length");
    mgt_syncok = '1;
    wait_status(SYNC_BITS | ALIGN_BIT, SYNC_BITS | ALIGN_BIT, 16, "realigned link");
    pulse_xaui_reset();
    expect_quiet(QUIET_CYCLES, "receive reset after recovery");
  endtask

  task automatic buffer_fault();
    logic [7:0] r;
    r = lfsr_take(2);
    mgt_rxbufferr[r[1:0]] = 1'b1;
    @(negedge mgt_clk);
    mgt_rxbufferr = '0;
    wait_status(BUF_BIT, BUF_BIT, 4, "buffer fault bit");
    repeat (8) @(negedge mgt_clk);
    check_status(xaui_status & BUF_BIT, BUF_BIT, "sticky buffer fault");
    check_count(error_count, 8'd1, "error count after one buffer error");
    pulse_xaui_reset();
    check_status(xaui_status & BUF_BIT, 8'h00, "buffer fault after xaui_reset");
    check_count(error_count, 8'd0, "error count after xaui_reset");
  endtask

  task automatic code_errors();
    int errs;
    int cycles;
    logic [7:0] r;
    errs = 0;
    cycles = 0;
    while (errs < 300 && cycles < 1200) begin
      mgt_code_valid = '1;
      if (lfsr_take(1) != 8'h00) begin
        r = lfsr_take(3);
        mgt_code_valid[r[2:0]] = 1'b0;
        errs++;
      end
      @(negedge mgt_clk);
      cycles++;
      if (cycles == 60) begin
        check_count(error_count, 8'(errs), "error count below saturation");
      end
    end
    mgt_code_valid = '1;
    if (errs < 300) begin
      timeouts++;
      $display("Code error run ended before the counter could saturate");
    end
    check_count(error_count, 8'(errs > 255 ? 255 : errs), "saturated error count");
    wait_status(CODE_BIT, CODE_BIT, 4, "code fault bit");
    pulse_xaui_reset();
    check_status(xaui_status & CODE_BIT, 8'h00, "code fault after xaui_reset");
    check_count(error_count, 8'd0, "error count after xaui_reset");
  endtask

  initial begin
    mismatches = 0;
    timeouts = 0;
    lfsr_state = LFSR_SEED;
    mgt_rx_reset_stretch = 1'b1;
    mgt_rxlock = '0;
    mgt_syncok = '0;
    mgt_code_valid = '0;
    mgt_code_comma = '0;
    mgt_rxbufferr = '0;
    xaui_reset = 1'b0;
    repeat (8) @(negedge mgt_clk);
    check_status(xaui_status, 8'h00, "status after reset");
    check_lanes(mgt_rx_reset, 4'h0, "receive reset after reset");
    check_lanes(mgt_enable_align, 4'hf, "comma align enables after reset");
    check_lanes({3'b000, mgt_en_chan_sync}, 4'h0, "bonding enable after reset");
    mgt_rx_reset_stretch = 1'b0;
    link_bringup();
    sync_loss_pulse();
    holdoff_retry();
    buffer_fault();
    code_errors();
    $display("Finished with %0d mismatches and %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- xaui_phy_mgmt.f
hdl/xaui_mgmt_pkg.sv
hdl/xaui_mgmt_ifs.sv
hdl/lane_sync_monitor.sv
hdl/rx_fault_tracker.sv
hdl/rx_reset_sequencer.sv
hdl/xaui_phy_mgmt.sv
tb/tb_xaui_phy_mgmt.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_xaui_phy_mgmt
FILELIST  ?= xaui_phy_mgmt.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= sim passed

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
	  -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
